// ==== vlog.f ====
+incdir+hdl
hdl/memory_packet_pkg.sv
hdl/csr_index_config_pkg.sv
hdl/program_response_filter.sv
hdl/csr_index_config_assembler.sv
hdl/config_fifo.sv
hdl/csr_index_configure_memory.sv
testbench/csr_index_configure_memory_tb.sv

// ==== Bender.yml ====
package:
  name: csr_index_configure_memory

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/memory_packet_pkg.sv
      - hdl/csr_index_config_pkg.sv
      - hdl/program_response_filter.sv
      - hdl/csr_index_config_assembler.sv
      - hdl/config_fifo.sv
      - hdl/csr_index_configure_memory.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - testbench/csr_index_configure_memory_tb.sv

// ==== testbench/csr_index_configure_memory_tb.sv ====
// Testbench for the CSR index configuration collector, engine window base 16
// Stimulus is a table of memory response words, one word per clock
// Expected configurations come from a model of the run rules
// Runs are separated by idle cycles so each run closes before the next opens

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module csr_index_configure_memory_tb
    import memory_packet_pkg::*;
    import csr_index_config_pkg::*;
();

    localparam int seq_lo = 16;

    typedef struct packed {
        logic                    valid;
        memory_cmd_t             cmd;
        logic [`CSR_DATA_W-1:0]  offset;
        logic [`CSR_SHIFT_W-1:0] shift;
        logic [`CSR_DATA_W-1:0]  data;
        logic                    read_en;
    } step_t;

    logic               ap_clk = 1'b0;
    logic               areset_csr_index_generator;
    memory_packet_t     response_in;
    logic               config_read_en;
    csr_index_config_t  config_out;
    fifo_status_t       fifo_status;

    step_t                     steps[$];
    csr_index_config_payload_t exp_q[$];
    csr_index_config_payload_t model_cfg;
    csr_index_config_payload_t exp_cfg;
    logic                      model_active = 1'b0;
    int                        model_count = 0;
    int                        pushed_count = 0;
    int                        recv_count = 0;
    int                        hold_recv = 0;
    int                        hold_start = 0;
    int                        hold_end = 0;
    int                        cycle_count = 0;
    int                        cycle_limit = 200;

    csr_index_configure_memory #(
        .seq_base(seq_lo)
    ) uut (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .config_read_en            (config_read_en),
        .config_out                (config_out),
        .fifo_status               (fifo_status)
    );

    always #20 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            report_error($sformatf("Timeout after %0d cycles", cycle_limit));
        end
    end

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic add_word(input logic valid, input memory_cmd_t cmd, input int offset,
                            input int shift, input logic read_en);
        steps.push_back('{valid: valid, cmd: cmd, offset: offset, shift: shift,
                          data: $urandom, read_en: read_en});
    endtask

    task automatic add_idle(input int n, input logic read_en);
        for (int k = 0; k < n; k++) begin
            add_word(1'b0, cmd_invalid, 0, 0, read_en);
        end
    endtask

    // Counted words sit at 16 + k, noise words are dropped by the filter
    task automatic add_run(input logic read_en, input bit mixed, input bit alt_start);
        for (int k = 0; k < `CSR_SEQ_WIDTH; k++) begin
            if (k == 0 && alt_start) begin
                add_word(1'b1, cmd_mem_program, 32, 1, read_en);
            end else begin
                add_word(1'b1, cmd_mem_program, seq_lo + k, 0, read_en);
            end
            if (mixed) begin
                case (k % 4)
                    0: add_word(1'b1, cmd_mem_read, 20, 0, read_en);
                    1: add_word(1'b1, cmd_mem_program, 40, 0, read_en);
                    2: add_word(1'b1, cmd_mem_program, 12, 2, read_en);
                    default: add_word(1'b0, cmd_mem_program, 17, 0, read_en);
                endcase
            end
        end
    endtask

    task automatic build_table();
        add_idle(2, 1'b1);
        // Kept or base words while idle that must not open a run
        add_word(1'b1, cmd_mem_program, 20, 0, 1'b1);
        add_word(1'b1, cmd_mem_program, 31, 0, 1'b1);
        add_word(1'b1, cmd_mem_write, 16, 0, 1'b1);
        add_idle(2, 1'b1);
        add_run(1'b1, 1'b0, 1'b0);
        add_idle(6, 1'b1);
        add_run(1'b1, 1'b1, 1'b1);
        add_idle(6, 1'b1);
        add_word(1'b1, cmd_mem_program, 72, 2, 1'b1);
        add_idle(2, 1'b1);
        add_run(1'b1, 1'b0, 1'b0);
        add_idle(12, 1'b1);
        // Three runs queue up with the read enable low
        hold_start = steps.size();
        add_run(1'b0, 1'b0, 1'b0);
        add_idle(6, 1'b0);
        add_run(1'b0, 1'b1, 1'b0);
        add_idle(6, 1'b0);
        add_run(1'b0, 1'b0, 1'b1);
        add_idle(12, 1'b0);
        hold_end = steps.size();
        add_idle(12, 1'b1);
    endtask

    // ----------------------------------------
    // Reference model of the run rules
    // ----------------------------------------
    task automatic model_word(input step_t s);
        logic [`CSR_DATA_W-1:0] seq;
        seq = s.offset >> s.shift;
        if (s.valid && s.cmd == cmd_mem_program && seq >= seq_lo
                && seq < seq_lo + `CSR_SEQ_WIDTH) begin
            if (!model_active && seq == seq_lo) begin
                model_active = 1'b1;
                model_count  = 0;
            end
            if (model_active) begin
                case (model_count)
                    0: begin
                        model_cfg.param.increment     = s.data[0];
                        model_cfg.param.decrement     = s.data[1];
                        model_cfg.param.mode_sequence = s.data[2];
                        model_cfg.param.mode_buffer   = s.data[3];
                        model_cfg.param.mode_break    = s.data[4];
                    end
                    1: model_cfg.param.index_start = s.data;
                    2: model_cfg.param.index_end = s.data;
                    3: model_cfg.param.stride = s.data;
                    4: begin
                        model_cfg.param.granularity = s.data[4:0];
                        model_cfg.param.direction   = s.data[31];
                        model_cfg.shift_amount      = s.data[4:0];
                        model_cfg.shift_direction   = s.data[31];
                    end
                    5: begin
                        model_cfg.cmd         = memory_cmd_t'(s.data[1:0]);
                        model_cfg.dest_module = s.data[3:2];
                    end
                    7: model_cfg.param.array_size = s.data;
                    default: ;
                endcase
                model_count++;
                if (model_count == `CSR_SEQ_WIDTH) begin
                    exp_q.push_back(model_cfg);
                    pushed_count++;
                    model_active = 1'b0;
                end
            end
        end
    endtask

    task automatic compare_config(input int n, input csr_index_config_payload_t e,
                                  input csr_index_config_payload_t a);
        check_value($sformatf("cfg%0d increment", n), e.param.increment, a.param.increment);
        check_value($sformatf("cfg%0d decrement", n), e.param.decrement, a.param.decrement);
        check_value($sformatf("cfg%0d mode_sequence", n), e.param.mode_sequence,
                    a.param.mode_sequence);
        check_value($sformatf("cfg%0d mode_buffer", n), e.param.mode_buffer,
                    a.param.mode_buffer);
        check_value($sformatf("cfg%0d mode_break", n), e.param.mode_break, a.param.mode_break);
        check_value($sformatf("cfg%0d index_start", n), e.param.index_start,
                    a.param.index_start);
        check_value($sformatf("cfg%0d index_end", n), e.param.index_end, a.param.index_end);
        check_value($sformatf("cfg%0d stride", n), e.param.stride, a.param.stride);
        check_value($sformatf("cfg%0d granularity", n), e.param.granularity,
                    a.param.granularity);
        check_value($sformatf("cfg%0d direction", n), e.param.direction, a.param.direction);
        check_value($sformatf("cfg%0d array_size", n), e.param.array_size, a.param.array_size);
        check_value($sformatf("cfg%0d cmd", n), e.cmd, a.cmd);
        check_value($sformatf("cfg%0d dest_module", n), e.dest_module, a.dest_module);
        check_value($sformatf("cfg%0d shift_amount", n), e.shift_amount, a.shift_amount);
        check_value($sformatf("cfg%0d shift_direction", n), e.shift_direction,
                    a.shift_direction);
    endtask

    // Output monitor, sampled mid-cycle
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && config_out.valid) begin
            if (exp_q.size() == 0) begin
                report_error("Configuration appeared at the output when none was expected");
            end else begin
                exp_cfg = exp_q.pop_front();
                compare_config(recv_count, exp_cfg, config_out.payload);
                recv_count++;
            end
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        areset_csr_index_generator = 1'b1;
        response_in                = '0;
        config_read_en             = 1'b0;
        void'($urandom(32'hd4dfb8cd));
        build_table();
        cycle_limit = 4 * steps.size() + 200;

        repeat (3) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
        @(negedge ap_clk);
        check_value("reset config_out.valid", 0, config_out.valid);
        check_value("reset fifo empty", 1, fifo_status.empty);
        check_value("reset fifo full", 0, fifo_status.full);
        check_value("reset fifo busy", 1, fifo_status.busy);

        for (int i = 0; i < steps.size(); i++) begin
            @(negedge ap_clk);
            if (i == hold_start) begin
                check_value("first phase drained", pushed_count, recv_count);
                check_value("fifo busy after reset", 0, fifo_status.busy);
                hold_recv = recv_count;
            end
            if (i == hold_end) begin
                check_value("output while read disabled", hold_recv, recv_count);
                check_value("configs queued", hold_recv + 3, pushed_count);
                check_value("fifo empty while held", 0, fifo_status.empty);
                check_value("fifo prog_full while held", 0, fifo_status.prog_full);
            end
            @(posedge ap_clk);
            response_in <= '{valid: steps[i].valid, cmd: steps[i].cmd,
                             offset: steps[i].offset, shift_amount: steps[i].shift,
                             shift_direction: 1'b0, data: steps[i].data};
            config_read_en <= steps[i].read_en;
            model_word(steps[i]);
        end

        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
        end
        @(negedge ap_clk);
        check_value("fifo empty after drain", 1, fifo_status.empty);

        if (recv_count != pushed_count || pushed_count != 6) begin
            report_error($sformatf("Received %0d of %0d configurations, 6 runs were sent",
                                   recv_count, pushed_count));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule : csr_index_configure_memory_tb

`default_nettype wire

// ==== hdl/csr_index_configure_memory.sv ====
// CSR index configuration collector for one engine
// Input is a strobe per memory response, there is no input back-pressure
// Upstream must watch prog_full, configurations arriving at a full FIFO are lost
// config_read_en is a level and is registered once before the FIFO

`timescale 1ns/1ps
`default_nettype none

module csr_index_configure_memory
    import memory_packet_pkg::*;
    import csr_index_config_pkg::*;
#(
    parameter int seq_base = 0
) (
    input  wire logic           ap_clk,
    input  wire logic           areset_csr_index_generator,
    input  wire memory_packet_t response_in,
    input  wire logic           config_read_en,
    output csr_index_config_t   config_out,
    output fifo_status_t        fifo_status
);

    memory_packet_t            kept_word;
    logic                      run_start;
    logic                      config_wr_en;
    csr_index_config_payload_t config_wr_data;
    logic                      read_en_q;
    csr_index_config_t         fifo_rd_data;
    fifo_status_t              fifo_status_int;
    logic                      out_valid_q;
    csr_index_config_payload_t out_payload_q;

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    program_response_filter #(
        .seq_base(seq_base)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_in               (response_in),
        .kept_word                 (kept_word),
        .run_start                 (run_start)
    );

    csr_index_config_assembler u_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .kept_word                 (kept_word),
        .run_start                 (run_start),
        .config_wr_en              (config_wr_en),
        .config_wr_data            (config_wr_data)
    );

    config_fifo u_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (config_wr_en),
        .wr_data                   (config_wr_data),
        .rd_en                     (read_en_q),
        .rd_data                   (fifo_rd_data),
        .status                    (fifo_status_int)
    );

    // ----------------------------------------
    // Boundary registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            read_en_q   <= 1'b0;
            out_valid_q <= 1'b0;
            fifo_status <= '{full: 1'b0, empty: 1'b1, prog_full: 1'b0, busy: 1'b1};
        end else begin
            read_en_q   <= config_read_en;
            out_valid_q <= fifo_rd_data.valid;
            fifo_status <= fifo_status_int;
        end
    end

    always_ff @(posedge ap_clk) begin
        out_payload_q <= fifo_rd_data.payload;
    end

    assign config_out = '{valid: out_valid_q, payload: out_payload_q};

endmodule : csr_index_configure_memory

`default_nettype wire

// ==== hdl/config_fifo.sv ====
// Synchronous FIFO of configuration payloads, CSR_FIFO_DEPTH entries
// Writes while full are dropped, reads while empty are ignored
// rd_data.valid pulses one cycle after each accepted read
// busy stays high for one cycle after reset is released

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module config_fifo import csr_index_config_pkg::*; (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_csr_index_generator,
    input  wire logic                      wr_en,
    input  wire csr_index_config_payload_t wr_data,
    input  wire logic                      rd_en,
    output csr_index_config_t              rd_data,
    output fifo_status_t                   status
);

    localparam int addr_w = $clog2(`CSR_FIFO_DEPTH);

    csr_index_config_payload_t mem [`CSR_FIFO_DEPTH];
    csr_index_config_payload_t rd_payload_q;

    logic [addr_w-1:0] wr_ptr;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   count;
    logic              full;
    logic              empty;
    logic              push;
    logic              pop;
    logic              rd_valid_q;
    logic              busy_q;

    assign full  = (count == `CSR_FIFO_DEPTH);
    assign empty = (count == '0);
    assign push  = wr_en & ~full;
    assign pop   = rd_en & ~empty;

    // ----------------------------------------
    // Pointers and fill level
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_valid_q <= 1'b0;
            busy_q     <= 1'b1;
        end else begin
            busy_q     <= 1'b0;
            rd_valid_q <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
        if (pop) begin
            rd_payload_q <= mem[rd_ptr];
        end
    end

    assign rd_data = '{valid: rd_valid_q, payload: rd_payload_q};

    assign status = '{
        full:      full,
        empty:     empty,
        prog_full: (count >= `CSR_FIFO_PROG_THRESH),
        busy:      busy_q
    };

endmodule : config_fifo

`default_nettype wire

// ==== hdl/csr_index_config_assembler.sv ====
// Collects one configuration from a run of CSR_SEQ_WIDTH kept words
// A run opens only on a run_start word while idle, later words count in order
// Words 6 and 8 upward are counted and dropped
// config_wr_en is a single pulse, config_wr_data holds until the next run decodes
// No back-pressure, the consumer must take every pulse

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module csr_index_config_assembler
    import memory_packet_pkg::*;
    import csr_index_config_pkg::*;
(
    input  wire logic                ap_clk,
    input  wire logic                areset_csr_index_generator,
    input  wire memory_packet_t      kept_word,
    input  wire logic                run_start,
    output logic                     config_wr_en,
    output csr_index_config_payload_t config_wr_data
);

    typedef logic [`CSR_SEQ_WIDTH-1:0] position_t;

    position_t                 position;
    logic                      done_pulse;
    logic                      word_valid_q;
    logic [`CSR_DATA_W-1:0]    data_q;
    csr_index_config_payload_t cfg_q;

    // ----------------------------------------
    // Run position, one-hot
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            position     <= '0;
            done_pulse   <= 1'b0;
            config_wr_en <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            // Single pulse even if the last slot is held for a while
            done_pulse   <= position[`CSR_SEQ_WIDTH-1] & ~done_pulse;
            config_wr_en <= done_pulse;
            word_valid_q <= kept_word.valid;

            if (kept_word.valid) begin
                if (run_start && (position == '0)) begin
                    position <= position_t'(1);
                end else begin
                    // Idle with no start keeps shifting zeros
                    position <= position << 1;
                end
            end else if (done_pulse) begin
                position <= '0;
            end
        end
    end

    // Data delayed to line up with its position bit
    always_ff @(posedge ap_clk) begin
        data_q <= kept_word.data;
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (word_valid_q) begin
            case (position)
                position_t'(1 << 0): begin
                    cfg_q.param.increment     <= data_q[0];
                    cfg_q.param.decrement     <= data_q[1];
                    cfg_q.param.mode_sequence <= data_q[2];
                    cfg_q.param.mode_buffer   <= data_q[3];
                    cfg_q.param.mode_break    <= data_q[4];
                end
                position_t'(1 << 1): begin
                    cfg_q.param.index_start <= data_q;
                end
                position_t'(1 << 2): begin
                    cfg_q.param.index_end <= data_q;
                end
                position_t'(1 << 3): begin
                    cfg_q.param.stride <= data_q;
                end
                position_t'(1 << 4): begin
                    // Granularity doubles as the output address shift
                    cfg_q.param.granularity <= data_q[`CSR_SHIFT_W-1:0];
                    cfg_q.param.direction   <= data_q[`CSR_DATA_W-1];
                    cfg_q.shift_amount      <= data_q[`CSR_SHIFT_W-1:0];
                    cfg_q.shift_direction   <= data_q[`CSR_DATA_W-1];
                end
                position_t'(1 << 5): begin
                    cfg_q.cmd <= memory_cmd_t'(data_q[`CSR_CMD_W-1:0]);
                    cfg_q.dest_module <=
                        data_q[`CSR_CMD_W+`CSR_MODULE_W-1:`CSR_CMD_W];
                end
                position_t'(1 << 7): begin
                    cfg_q.param.array_size <= data_q;
                end
                default: begin
                    cfg_q <= cfg_q;
                end
            endcase
        end
    end

    assign config_wr_data = cfg_q;

endmodule : csr_index_config_assembler

`default_nettype wire

// ==== hdl/program_response_filter.sv ====
// Input stage of the collector, one register deep
// Keeps program words whose sequence number lies in [seq_base, seq_base + 16)
// run_start flags a kept word that sits exactly at seq_base
// seq_base is expected to be a multiple of CSR_SEQ_WIDTH

`timescale 1ns/1ps
`default_nettype none

`include "csr_index_consts.svh"

module program_response_filter import memory_packet_pkg::*; #(
    parameter int seq_base = 0
) (
    input  wire logic           ap_clk,
    input  wire logic           areset_csr_index_generator,
    input  wire memory_packet_t response_in,
    output memory_packet_t      kept_word,
    output logic                run_start
);

    localparam logic [`CSR_DATA_W-1:0] seq_lo = seq_base;
    localparam logic [`CSR_DATA_W-1:0] seq_hi = seq_base + `CSR_SEQ_WIDTH;

    logic [`CSR_DATA_W-1:0] seq_num;
    logic                   is_program;
    logic                   in_window;
    logic                   keep_valid_q;
    memory_packet_t         word_q;

    // ----------------------------------------
    // Window decode on the raw response
    // ----------------------------------------
    assign seq_num    = response_in.offset >> response_in.shift_amount;
    assign is_program = (response_in.cmd == cmd_mem_program);
    assign in_window  = (seq_num >= seq_lo) && (seq_num < seq_hi);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            keep_valid_q <= 1'b0;
            run_start    <= 1'b0;
        end else begin
            keep_valid_q <= response_in.valid & is_program & in_window;
            run_start    <= response_in.valid & is_program & (seq_num == seq_lo);
        end
    end

    // Payload copy
    always_ff @(posedge ap_clk) begin
        word_q <= response_in;
    end

    // Registered word with the filtered strobe
    always_comb begin
        kept_word       = word_q;
        kept_word.valid = keep_valid_q;
    end

endmodule : program_response_filter

`default_nettype wire

// ==== hdl/csr_index_config_pkg.sv ====
// Configuration and FIFO status types of the collector
// The command field reuses the memory command encoding
// Compile after memory_packet_pkg

`default_nettype none

`include "csr_index_consts.svh"

package csr_index_config_pkg;

    // ----------------------------------------
    // Index generator parameters
    // ----------------------------------------
    typedef struct packed {
        logic                    increment;
        logic                    decrement;
        logic                    mode_sequence;
        logic                    mode_buffer;
        logic                    mode_break;
        logic [`CSR_DATA_W-1:0]  index_start;
        logic [`CSR_DATA_W-1:0]  index_end;
        logic [`CSR_DATA_W-1:0]  stride;
        logic [`CSR_SHIFT_W-1:0] granularity;
        logic                    direction;
        logic [`CSR_DATA_W-1:0]  array_size;
    } csr_index_params_t;

    // Entry stored in the output FIFO
    typedef struct packed {
        csr_index_params_t            param;
        memory_packet_pkg::memory_cmd_t cmd;
        logic [`CSR_MODULE_W-1:0]     dest_module;
        logic [`CSR_SHIFT_W-1:0]      shift_amount;
        logic                         shift_direction;
    } csr_index_config_payload_t;

    typedef struct packed {
        logic                      valid;
        csr_index_config_payload_t payload;
    } csr_index_config_t;

    // ----------------------------------------
    // FIFO status levels
    // ----------------------------------------
    typedef struct packed {
        logic full;
        logic empty;
        logic prog_full;
        logic busy;
    } fifo_status_t;

endpackage : csr_index_config_pkg

`default_nettype wire

// ==== hdl/memory_packet_pkg.sv ====
// Memory response types seen at the collector input
// Only cmd_mem_program words are of interest to this design
// Widths come from csr_index_consts.svh

`default_nettype none

`include "csr_index_consts.svh"

package memory_packet_pkg;

    // ----------------------------------------
    // Memory commands
    // ----------------------------------------
    typedef enum logic [`CSR_CMD_W-1:0] {
        cmd_invalid     = 2'd0,
        cmd_mem_read    = 2'd1,
        cmd_mem_write   = 2'd2,
        cmd_mem_program = 2'd3
    } memory_cmd_t;

    // ----------------------------------------
    // Response packet
    // ----------------------------------------
    // Sequence number of a word is offset >> shift_amount
    typedef struct packed {
        logic                    valid;
        memory_cmd_t             cmd;
        logic [`CSR_DATA_W-1:0]  offset;
        logic [`CSR_SHIFT_W-1:0] shift_amount;
        logic                    shift_direction;
        logic [`CSR_DATA_W-1:0]  data;
    } memory_packet_t;

endpackage : memory_packet_pkg

`default_nettype wire

// ==== hdl/csr_index_consts.svh ====
// Sizing constants for the CSR index configuration collector
// CSR_FIFO_DEPTH must be a power of two, the FIFO pointers wrap naturally
// CSR_SEQ_WIDTH is both the window size and the run length in words
// CSR_SHIFT_W must cover log2 of CSR_DATA_W

`ifndef CSR_INDEX_CONSTS_SVH
`define CSR_INDEX_CONSTS_SVH

// Data path
`define CSR_DATA_W 32
`define CSR_SHIFT_W 5

// Sequence slots per engine, also the words per run
`define CSR_SEQ_WIDTH 16

// Output FIFO
`define CSR_FIFO_DEPTH 16
`define CSR_FIFO_PROG_THRESH 8

// Fields packed into configuration word 5
`define CSR_CMD_W 2
`define CSR_MODULE_W 2

`endif
